/* build.f */
hdl/eeprom_pkg.sv
hdl/eeprom_axil_regs.sv
hdl/eeprom_wr.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/eeprom_assertions.sv
test/tb_eeprom_ctrl.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - hdl/eeprom_pkg.sv
  - hdl/eeprom_axil_regs.sv
  - hdl/eeprom_wr.sv
  - hdl/i2c_bit_engine.sv
  - hdl/eeprom_ctrl_top.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/eeprom_assertions.sv
      - test/tb_eeprom_ctrl.sv

/* test/tb_eeprom_ctrl.sv */
`timescale 1ns/10ps

module tb_eeprom_ctrl import eeprom_pkg::*; ();

    localparam int n_trans     = 49;
    localparam int cycle_limit = n_trans * 800 + 2000;

    logic                   CLK;
    logic                   RESET;
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [axil_data_w-1:0] wdata;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic                   ack_en;
    tri1                    scl;
    tri1                    sda;  // pull-ups

    integer     seed = 32'hd5d;
    int         cycles = 0;
    logic [7:0] shadow [0:2047];

    eeprom_ctrl_top i_eeprom_ctrl_top (.*);

    eeprom_model i_model (.scl, .sda, .ack_en);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // bound protocol checks
    always @(posedge CLK) begin
        if (i_eeprom_ctrl_top.i_assertions.n_errors != 0) begin
            $display("a bus or handshake assertion failed at %0t", $time);
            $display("Test failed");
            $fatal(1, "assertion failed");
        end
    end

    // reference model of the memory and the status word
    function automatic logic [7:0] expected_byte(input logic [10:0] a);
        return shadow[a];
    endfunction

    function automatic logic [2:0] expected_status(input logic acked);
        return acked ? 3'b010 : 3'b110;  // nack, done, busy
    endfunction

    task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                  input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("Test failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
        int hold;
        hold = $unsigned($random(seed)) % 4;
        @(posedge CLK);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge CLK); while (!(awready && wready));
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (hold) begin
            @(posedge CLK);
            #1;
        end
        bready = 1'b1;
        do @(posedge CLK); while (!bvalid);
        compare_values(bresp, resp_okay, "write response");
        #1;
        bready = 1'b0;
        compare_values(bvalid, 1'b0, "write response repeated");
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [31:0] data);
        int hold;
        hold = $unsigned($random(seed)) % 4;
        @(posedge CLK);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge CLK); while (!arready);
        #1;
        arvalid = 1'b0;
        repeat (hold) begin
            @(posedge CLK);
            #1;
        end
        rready = 1'b1;
        do @(posedge CLK); while (!rvalid);
        data = rdata;
        compare_values(rresp, resp_okay, "read response");
        #1;
        rready = 1'b0;
        compare_values(rvalid, 1'b0, "read response repeated");
    endtask

    task automatic wait_done(output logic [31:0] status);
        logic [31:0] s;
        do axil_read(reg_status, s); while (!s[1]);
        status = s;
    endtask

    task automatic eeprom_write(input logic [10:0] a, input logic [7:0] d);
        logic [31:0] s;
        axil_write(reg_addr, a);
        axil_write(reg_wdata, d);
        axil_write(reg_ctrl, 32'h1);
        wait_done(s);
        compare_values(s[2:0], expected_status(ack_en), "write status");
        if (ack_en)
            shadow[a] = d;
    endtask

    task automatic eeprom_read(input logic [10:0] a, output logic [7:0] d);
        logic [31:0] s;
        logic [31:0] r;
        axil_write(reg_addr, a);
        axil_write(reg_ctrl, 32'h2);
        wait_done(s);
        compare_values(s[2:0], expected_status(ack_en), "read status");
        axil_read(reg_rdata, r);
        d = r[7:0];
    endtask

    initial begin
        logic [10:0] a;
        logic [7:0]  d;
        logic [7:0]  r;
        logic [31:0] v;
        RESET   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        ack_en  = 1'b1;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;

        compare_values(scl, 1'b1, "scl after reset");
        compare_values(sda, 1'b1, "sda after reset");
        axil_read(reg_status, v);
        compare_values(v, 32'h0, "status after reset");

        for (int i = 0; i < 20; i++) begin
            a = {3'(i), 8'($random(seed))};  // every high-address block
            d = 8'($random(seed));
            eeprom_write(a, d);
            eeprom_read(a, r);
            compare_values(r, expected_byte(a), "read back");
        end

        a = 11'h7fe;  // never written
        eeprom_read(a, r);
        compare_values(r, expected_byte(a), "erased byte");

        // leave a non-erased byte in rdata
        eeprom_write(11'h35a, 8'h69);
        eeprom_read(11'h35a, r);
        compare_values(r, expected_byte(11'h35a), "read before absent device");

        // absent device
        ack_en = 1'b0;
        eeprom_write(11'h123, 8'h3c);
        eeprom_read(11'h123, r);
        compare_values(r, expected_byte(11'h35a), "rdata kept after nack");
        ack_en = 1'b1;
        eeprom_read(11'h123, r);
        compare_values(r, expected_byte(11'h123), "memory after nack write");

        // command while busy is dropped
        a = 11'h2c4;
        eeprom_write(a, 8'h5a);
        axil_write(reg_addr, a);
        axil_write(reg_ctrl, 32'h2);
        axil_read(reg_status, v);
        compare_values(v[0], 1'b1, "busy during read");
        axil_write(reg_wdata, 32'ha5);
        axil_write(reg_ctrl, 32'h1);
        wait_done(v);
        eeprom_read(a, r);
        compare_values(r, expected_byte(a), "memory after dropped write");

        axil_read(5'h14, v);
        compare_values(v, 32'h0, "unmapped offset");
        axil_read(5'h1c, v);
        compare_values(v, 32'h0, "unmapped offset");

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* test/eeprom_assertions.sv */
`timescale 1ns/10ps

module eeprom_assertions import eeprom_pkg::*; (
    input logic          CLK,
    input logic          RESET,
    input logic          scl,
    input logic          sda,
    input logic          bvalid,
    input logic          bready,
    input logic          rvalid,
    input logic          rready,
    input eeprom_state_t state
);

    int n_errors = 0;  // failures so far

    // sda only moves with scl low, apart from start and stop
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda != $past(sda)) |-> state inside {st_start, st_restart, st_stop})
        else begin
            $error("sda changed while scl high outside start or stop");
            n_errors++;
        end

    bvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        (bvalid && !bready) |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            n_errors++;
        end

    rvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        (rvalid && !rready) |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            n_errors++;
        end

endmodule

bind eeprom_ctrl_top eeprom_assertions i_assertions (
    .CLK, .RESET, .scl, .sda, .bvalid, .bready, .rvalid, .rready,
    .state (i_wr.state)
);

/* test/eeprom_model.sv */
`timescale 1ns/10ps

module eeprom_model import eeprom_pkg::*; (
    input  wire  scl,
    inout  wire  sda,
    input  logic ack_en  // low models an absent device
);

    typedef enum logic [2:0] {m_idle, m_ctrl, m_addr, m_wdata, m_rdata} mode_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode = m_idle;
    mode_t       mode_nxt = m_idle;
    int          bitcnt = 0;
    logic [7:0]  shreg = 8'h00;
    logic [7:0]  dout = 8'h00;
    logic [2:0]  blk = 3'd0;
    logic [10:0] ptr = 11'd0;
    logic        drive_low = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;  // erased
    end

    // start and stop move sda while scl is high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            mode      = m_ctrl;
            bitcnt    = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            mode   = m_idle;
            bitcnt = 0;
        end
    end

    always @(posedge scl) begin
        if (mode != m_idle) begin
            if (bitcnt < 8)
                shreg = {shreg[6:0], sda};
            bitcnt = bitcnt + 1;
        end
    end

    // sda only changes after scl falls
    always @(negedge scl) begin
        if (mode != m_idle) begin
            if (bitcnt == 8) begin
                drive_low = 1'b0;
                case (mode)
                    m_ctrl: begin
                        if (shreg[7:4] == eeprom_dev_code && ack_en) begin
                            blk       = shreg[3:1];
                            mode_nxt  = shreg[0] ? m_rdata : m_addr;
                            drive_low = 1'b1;
                        end else begin
                            mode = m_idle;  // not addressed
                        end
                    end
                    m_addr: begin
                        ptr       = {blk, shreg};
                        mode_nxt  = m_wdata;
                        drive_low = ack_en;
                    end
                    m_wdata: begin
                        if (ack_en)
                            mem[ptr] = shreg;
                        mode_nxt  = m_idle;
                        drive_low = ack_en;
                    end
                    default: mode_nxt = m_idle;  // master acks read data
                endcase
            end else if (bitcnt == 9) begin
                bitcnt    = 0;
                mode      = mode_nxt;
                drive_low = 1'b0;
                if (mode == m_rdata) begin
                    dout      = mem[ptr];
                    drive_low = ~dout[7];
                end
            end else if (mode == m_rdata) begin
                drive_low = ~dout[7 - bitcnt];
            end
        end
    end

endmodule

/* hdl/eeprom_ctrl_top.sv */
`timescale 1ns/10ps

module eeprom_ctrl_top import eeprom_pkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic [axil_addr_w-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [axil_data_w-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [axil_addr_w-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [axil_data_w-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output wire                    scl,
    inout  wire                    sda
);

    logic                  cmd_write, cmd_read;
    logic [mem_addr_w-1:0] mem_addr;
    logic [7:0]            wr_byte, rd_byte;
    logic                  busy, done, nack;
    logic                  op_valid, op_ready, op_done, tx_last, ack_in;
    bit_op_t               op;
    logic [7:0]            tx_byte, rx_byte;
    logic                  scl_low, sda_low;

    // open drain, pull-ups are external
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_axil_regs i_regs (
        .CLK, .RESET,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .done, .nack, .rd_byte,
        .cmd_write, .cmd_read, .mem_addr, .wr_byte
    );

    eeprom_wr i_wr (
        .CLK, .RESET,
        .cmd_write, .cmd_read, .mem_addr, .wr_byte,
        .busy, .done, .nack, .rd_byte,
        .op_valid, .op, .tx_byte, .tx_last,
        .op_ready, .op_done, .rx_byte, .ack_in
    );

    i2c_bit_engine i_engine (
        .CLK, .RESET,
        .op_valid, .op, .tx_byte, .tx_last,
        .op_ready, .op_done, .rx_byte, .ack_in,
        .scl_low, .sda_low,
        .sda_in (sda)
    );

endmodule

/* hdl/i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine import eeprom_pkg::*; (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       op_valid,
    input  bit_op_t    op,
    input  logic [7:0] tx_byte,
    input  logic       tx_last,
    output logic       op_ready,
    output logic       op_done,
    output logic [7:0] rx_byte,
    output logic       ack_in,
    output logic       scl_low,
    output logic       sda_low,
    input  logic       sda_in
);

    logic       running;
    bit_op_t    cur_op;
    logic [3:0] qcnt;    // cycles within a quarter
    logic [1:0] phase;   // quarter within a bit
    logic [3:0] bitcnt;  // 0..7 data, 8 ack
    logic [7:0] shreg;
    logic       last;
    logic       quarter_end;
    logic       sample;
    logic       is_byte;
    logic       data_bit;
    logic       scl_nxt;
    logic       sda_nxt;

    assign op_ready    = ~running;
    assign rx_byte     = shreg;
    assign quarter_end = (qcnt == 4'(scl_quarter - 1));
    assign sample      = running && phase == 2'd2 && qcnt == 4'd0;  // mid high phase
    assign is_byte     = (cur_op == op_tx_byte) || (cur_op == op_rx_byte);
    assign data_bit    = (bitcnt != 4'd8);

    // line levels per quarter, scl low in quarters 0 and 3
    always_comb begin
        scl_nxt = (phase == 2'd0) || (phase == 2'd3);
        sda_nxt = 1'b0;
        case (cur_op)
            op_start: sda_nxt = phase[1];  // sda falls while scl high
            op_stop: begin
                scl_nxt = (phase == 2'd0);
                sda_nxt = ~phase[1];       // sda rises while scl high
            end
            op_tx_byte: sda_nxt = data_bit ? ~shreg[7] : 1'b0;
            op_rx_byte: sda_nxt = data_bit ? 1'b0 : ~last;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            running <= 1'b0;
            cur_op  <= op_start;
            op_done <= 1'b0;
            qcnt    <= '0;
            phase   <= '0;
            bitcnt  <= '0;
            ack_in  <= 1'b0;
            scl_low <= 1'b0;  // bus released
            sda_low <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!running) begin
                if (op_valid) begin
                    running <= 1'b1;
                    cur_op  <= op;
                    qcnt    <= '0;
                    phase   <= '0;
                    bitcnt  <= '0;
                    ack_in  <= 1'b0;
                end
            end else begin
                scl_low <= scl_nxt;
                sda_low <= sda_nxt;
                if (quarter_end) begin
                    qcnt  <= '0;
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        if (is_byte && data_bit) begin
                            bitcnt <= bitcnt + 4'd1;
                        end else begin
                            running <= 1'b0;
                            op_done <= 1'b1;
                        end
                    end
                end else begin
                    qcnt <= qcnt + 4'd1;
                end
                if (sample && is_byte && !data_bit)
                    ack_in <= ~sda_in;  // slave pulled sda low
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!running && op_valid) begin
            shreg <= tx_byte;
            last  <= tx_last;
        end else if (running && data_bit) begin
            if (cur_op == op_rx_byte && sample)
                shreg <= {shreg[6:0], sda_in};
            else if (cur_op == op_tx_byte && quarter_end && phase == 2'd3)
                shreg <= {shreg[6:0], 1'b0};  // next bit to msb
        end
    end

endmodule

/* hdl/eeprom_wr.sv */
`timescale 1ns/10ps

module eeprom_wr import eeprom_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESET,
    // command side
    input  logic                  cmd_write,
    input  logic                  cmd_read,
    input  logic [mem_addr_w-1:0] mem_addr,
    input  logic [7:0]            wr_byte,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic [7:0]            rd_byte,
    // bit engine side
    output logic                  op_valid,
    output bit_op_t               op,
    output logic [7:0]            tx_byte,
    output logic                  tx_last,
    input  logic                  op_ready,
    input  logic                  op_done,
    input  logic [7:0]            rx_byte,
    input  logic                  ack_in
);

    eeprom_state_t         state;
    eeprom_state_t         state_nxt;
    logic                  launch;  // op for current state not yet issued
    logic                  rd_mode;
    logic [mem_addr_w-1:0] addr_q;
    logic [7:0]            data_q;

    assign busy     = (state != st_idle);
    assign done     = (state == st_done);
    assign op_valid = launch & op_ready;

    // operation for each state
    always_comb begin
        op      = op_start;
        tx_byte = 8'h00;
        tx_last = 1'b0;
        case (state)
            st_start,
            st_restart: op = op_start;
            st_ctrl_w: begin
                op      = op_tx_byte;
                tx_byte = {eeprom_dev_code, addr_q[10:8], 1'b0};
            end
            st_addr: begin
                op      = op_tx_byte;
                tx_byte = addr_q[7:0];
            end
            st_data_w: begin
                op      = op_tx_byte;
                tx_byte = data_q;
            end
            st_ctrl_r: begin
                op      = op_tx_byte;
                tx_byte = {eeprom_dev_code, addr_q[10:8], 1'b1};
            end
            st_data_r: begin
                op      = op_rx_byte;
                tx_last = 1'b1;  // single byte, end with nack
            end
            st_stop: op = op_stop;
            default: ;
        endcase
    end

    // where to go once the running op finishes
    always_comb begin
        state_nxt = state;
        case (state)
            st_start:   state_nxt = st_ctrl_w;
            st_ctrl_w:  state_nxt = ack_in ? st_addr : st_stop;
            st_addr: begin
                if (!ack_in)
                    state_nxt = st_stop;
                else
                    state_nxt = rd_mode ? st_restart : st_data_w;
            end
            st_data_w:  state_nxt = st_stop;
            st_restart: state_nxt = st_ctrl_r;
            st_ctrl_r:  state_nxt = ack_in ? st_data_r : st_stop;
            st_data_r:  state_nxt = st_stop;
            st_stop:    state_nxt = st_done;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= st_idle;
            launch  <= 1'b0;
            rd_mode <= 1'b0;
            nack    <= 1'b0;
            rd_byte <= '0;
        end else begin
            if (op_valid)
                launch <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_write || cmd_read) begin
                        state   <= st_start;
                        launch  <= 1'b1;
                        rd_mode <= cmd_read & ~cmd_write;
                        nack    <= 1'b0;
                    end
                end
                st_done: state <= st_idle;  // done lasts one cycle
                default: begin
                    if (op_done) begin
                        state  <= state_nxt;
                        launch <= (state_nxt != st_done);
                        if (state inside {st_ctrl_w, st_addr, st_data_w, st_ctrl_r} && !ack_in)
                            nack <= 1'b1;
                        if (state == st_data_r)
                            rd_byte <= rx_byte;
                    end
                end
            endcase
        end
    end

    // host registers may change while busy
    always_ff @(posedge CLK) begin
        if (state == st_idle && (cmd_write || cmd_read)) begin
            addr_q <= mem_addr;
            data_q <= wr_byte;
        end
    end

endmodule

/* hdl/eeprom_axil_regs.sv */
`timescale 1ns/10ps

module eeprom_axil_regs import eeprom_pkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    // write address / data / response
    input  logic [axil_addr_w-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [axil_data_w-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // read address / data
    input  logic [axil_addr_w-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [axil_data_w-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // sequencer side
    input  logic                   busy,
    input  logic                   done,
    input  logic                   nack,
    input  logic [7:0]             rd_byte,
    output logic                   cmd_write,
    output logic                   cmd_read,
    output logic [mem_addr_w-1:0]  mem_addr,
    output logic [7:0]             wr_byte
);

    logic                   wr_go;
    logic                   rd_go;
    logic                   done_flag;
    logic                   nack_flag;
    logic [7:0]             rdata_q;
    logic [axil_data_w-1:0] read_mux;

    assign wr_go = awready & awvalid & wready & wvalid;
    assign rd_go = arready & arvalid;

    assign bresp = resp_okay;
    assign rresp = resp_okay;

    // aw and w taken together, one cycle after both are offered
    always_ff @(posedge CLK) begin
        if (RESET) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (wr_go) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (!awready && !bvalid && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cmd_write <= 1'b0;
            cmd_read  <= 1'b0;
            mem_addr  <= '0;
            wr_byte   <= '0;
        end else begin
            cmd_write <= 1'b0;  // pulses
            cmd_read  <= 1'b0;
            if (wr_go) begin
                case (awaddr)
                    reg_ctrl: begin
                        // dropped while a transaction runs
                        cmd_write <= wdata[ctrl_wr_bit] & ~busy;
                        cmd_read  <= wdata[ctrl_rd_bit] & ~wdata[ctrl_wr_bit] & ~busy;
                    end
                    reg_addr:  mem_addr <= wdata[mem_addr_w-1:0];
                    reg_wdata: wr_byte  <= wdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    // result capture, done is sticky until status is read
    always_ff @(posedge CLK) begin
        if (RESET) begin
            done_flag <= 1'b0;
            nack_flag <= 1'b0;
            rdata_q   <= '0;
        end else if (done) begin
            done_flag <= 1'b1;
            nack_flag <= nack;
            rdata_q   <= rd_byte;
        end else if (rd_go && araddr == reg_status) begin
            done_flag <= 1'b0;
        end
    end

    always_comb begin
        read_mux = '0;
        case (araddr)
            reg_addr:   read_mux[mem_addr_w-1:0] = mem_addr;
            reg_wdata:  read_mux[7:0] = wr_byte;
            reg_status: read_mux[2:0] = {nack_flag, done_flag, busy};
            reg_rdata:  read_mux[7:0] = rdata_q;
            default: ;  // ctrl and unmapped read zero
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (rd_go) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end else if (!arready && !rvalid && arvalid) begin
                arready <= 1'b1;
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_go)
            rdata <= read_mux;
    end

endmodule

/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    // AXI4-Lite bus
    localparam int axil_addr_w = 5;
    localparam int axil_data_w = 32;
    localparam logic [1:0] resp_okay = 2'b00;

    // register map, byte offsets
    localparam logic [axil_addr_w-1:0] reg_ctrl   = 5'h00;  // write only
    localparam logic [axil_addr_w-1:0] reg_addr   = 5'h04;
    localparam logic [axil_addr_w-1:0] reg_wdata  = 5'h08;
    localparam logic [axil_addr_w-1:0] reg_status = 5'h0C;  // read clears done
    localparam logic [axil_addr_w-1:0] reg_rdata  = 5'h10;

    // bits of reg_ctrl
    localparam int ctrl_wr_bit = 0;
    localparam int ctrl_rd_bit = 1;

    // 24C16 memory
    localparam int mem_addr_w = 11;
    localparam logic [3:0] eeprom_dev_code = 4'b1010;

    // CLK cycles per quarter SCL period
    localparam int scl_quarter = 2;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_w,
        st_addr,
        st_data_w,
        st_restart,
        st_ctrl_r,
        st_data_r,
        st_stop,
        st_done
    } eeprom_state_t;

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_tx_byte,
        op_rx_byte
    } bit_op_t;

endpackage
